// File: chip_io.f
src/chip_io_pkg.sv
src/chip_io_if.sv
src/io_ctrl.sv
src/jtag_overlay.sv
src/pad_ring.sv
src/jtag_tap.sv
src/chip_io_top.sv
test/chip_io_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= chip_io_tb
FILELIST  ?= chip_io.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/chip_io_tb.sv
////////////////////
// Testbench for the pad side top level covering strap modes, attributes and the TAP
// Runs as the simulation top and prints one line per test and a closing result line
////////////////////

`timescale 1ns/1ps
`default_nettype none

module chip_io_tb;

  localparam int NumIos    = 12;
  localparam int JtagEnIdx = 7;
  localparam int TrstIdx   = 6;
  localparam int TckIdx    = 8;
  localparam int TmsIdx    = 9;
  localparam int TdiIdx    = 10;
  localparam int TdoIdx    = 11;
  localparam logic [11:0] TieOffValues = 12'h1 << TmsIdx;
  localparam logic [31:0] IdCode       = 32'h1000_36CF;
  localparam logic [11:0] JtagMask     = (12'h1 << TrstIdx) | (12'h1 << TckIdx) |
                                         (12'h1 << TmsIdx) | (12'h1 << TdiIdx) |
                                         (12'h1 << TdoIdx);

  logic        clk_i;
  logic        arst_n_i;
  logic [11:0] pad_in_i;
  logic [11:0] pad_out_o;
  logic [11:0] pad_oe_o;
  logic [11:0] core_out_i;
  logic [11:0] core_oe_i;
  logic [11:0] core_in_o;
  logic        cfg_we_i;
  logic [3:0]  cfg_idx_i;
  logic [2:0]  cfg_attr_i;
  logic        jtag_active_o;

  logic [2:0]  attr_ref [NumIos];  // Attributes as written to the DUT
  integer      seed = 32'h32e36c9b;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          err_mark = 0;

  chip_io_top chip_io_top_i (
    .clk_i, .arst_n_i, .pad_in_i, .pad_out_o, .pad_oe_o, .core_out_i, .core_oe_i,
    .core_in_o, .cfg_we_i, .cfg_idx_i, .cfg_attr_i, .jtag_active_o
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Returns {core_in, pad_oe, pad_out} with pads enabled
  function automatic logic [35:0] ref_pads(input logic [11:0] c_out, input logic [11:0] c_oe,
                                           input logic [11:0] p_in, input logic jtag);
    logic [11:0] bus_out;
    logic [11:0] bus_oe;
    logic [11:0] bus_in;
    logic [11:0] p_out;
    logic [11:0] p_oe;
    logic [11:0] c_in;
    logic        inv_out;
    bus_out = c_out;
    bus_oe  = c_oe;
    if (jtag) begin
      bus_oe         = c_oe & ~JtagMask;
      bus_oe[TdoIdx]  = 1'b1;
      bus_out[TdoIdx] = 1'b0;  // TDO value not modelled
    end
    for (int i = 0; i < NumIos; i++) begin
      inv_out   = bus_out[i] ^ attr_ref[i][0];
      p_out[i]  = attr_ref[i][1] ? 1'b0 : inv_out;
      p_oe[i]   = attr_ref[i][1] ? (bus_oe[i] & ~inv_out) : bus_oe[i];
      bus_in[i] = attr_ref[i][2] ? 1'b0 : (p_in[i] ^ attr_ref[i][0]);
    end
    c_in = jtag ? ((bus_in & ~JtagMask) | (TieOffValues & JtagMask)) : bus_in;
    return {c_in, p_oe, p_out};
  endfunction

  ////////////////////
  // Helpers
  ////////////////////

  task automatic step();
    @(posedge clk_i);
    #5;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      $display("error t=%0t %s exp=%h got=%h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s done, %0d errors", tests, name, errors - err_mark);
    err_mark = errors;
  endtask

  // Reset with the strap level on its pad and wait for the pads to open
  task automatic apply_reset(input logic strap);
    int n;
    arst_n_i   = 1'b0;
    cfg_we_i   = 1'b0;
    core_out_i = '0;
    core_oe_i  = '1;
    pad_in_i   = '0;
    pad_in_i[JtagEnIdx] = strap;
    for (int i = 0; i < NumIos; i++) attr_ref[i] = '0;
    repeat (4) begin
      step();
      check_value("pad_oe_o", 32'h0, 32'(pad_oe_o));
      check_value("jtag_active_o", 32'h0, 32'(jtag_active_o));
    end
    arst_n_i = 1'b1;
    #10;
    check_value("pad_oe_o", 32'h0, 32'(pad_oe_o));
    n = 0;
    while (pad_oe_o === 12'h0 && n < 8) begin
      step();
      #10;
      n++;
    end
    if (pad_oe_o === 12'h0) begin
      $display("timeout: pad outputs still disabled 8 cycles after reset");
      errors++;
      finish_run();
    end else begin
      check_value("jtag_active_o", 32'(strap), 32'(jtag_active_o));
    end
  endtask

  task automatic run_random(input int count, input logic jtag);
    logic [31:0] rnd;
    logic [35:0] exp;
    logic [11:0] out_mask;
    out_mask = jtag ? ~(12'h1 << TdoIdx) : 12'hFFF;
    for (int k = 0; k < count; k++) begin
      step();
      rnd = $random(seed);
      core_out_i = rnd[11:0];
      core_oe_i  = rnd[23:12];
      rnd = $random(seed);
      pad_in_i   = rnd[11:0];
      #10;  // Pad paths are combinational
      exp = ref_pads(core_out_i, core_oe_i, pad_in_i, jtag);
      check_value("pad_out_o", 32'(exp[11:0] & out_mask), 32'(pad_out_o & out_mask));
      check_value("pad_oe_o", 32'(exp[23:12]), 32'(pad_oe_o));
      check_value("core_in_o", 32'(exp[35:24]), 32'(core_in_o));
    end
  endtask

  // One TCK period with TDO read in the low phase before the rising edge
  task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
    step();
    pad_in_i[TckIdx] = 1'b0;
    pad_in_i[TmsIdx] = tms;
    pad_in_i[TdiIdx] = tdi;
    step();
    tdo = pad_out_o[TdoIdx];
    pad_in_i[TckIdx] = 1'b1;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  initial begin
    logic [31:0] rnd;
    logic [31:0] id_read;
    logic [8:0]  byp_read;
    logic [7:0]  pattern;
    logic        tdo;
    arst_n_i   = 1'b0;
    pad_in_i   = '0;
    core_out_i = '0;
    core_oe_i  = '1;
    cfg_we_i   = 1'b0;
    cfg_idx_i  = '0;
    cfg_attr_i = '0;

    apply_reset(1'b0);
    end_test("reset and strap low");

    run_random(50, 1'b0);
    end_test("functional passthrough");

    for (int i = 0; i < NumIos; i++) begin
      step();
      rnd = $random(seed);
      cfg_we_i    = 1'b1;
      cfg_idx_i   = 4'(i);
      cfg_attr_i  = rnd[2:0];
      attr_ref[i] = rnd[2:0];
    end
    step();
    cfg_we_i = 1'b0;
    run_random(50, 1'b0);
    end_test("random attributes");

    step();
    apply_reset(1'b1);
    run_random(50, 1'b1);
    end_test("jtag mode overlay");

    step();
    pad_in_i = '0;
    pad_in_i[TrstIdx] = 1'b1;
    repeat (5) tck_cycle(1'b1, 1'b0, tdo);  // Test-Logic-Reset
    tck_cycle(1'b0, 1'b0, tdo);
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);             // Now in Shift-DR
    for (int b = 0; b < 32; b++) begin
      tck_cycle(b == 31, 1'b0, tdo);
      id_read[b] = tdo;
    end
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);             // Back to Run-Test/Idle
    check_value("tdo idcode", IdCode, id_read);
    end_test("idcode read");

    // IR scan of BYPASS
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    for (int b = 0; b < 4; b++) tck_cycle(b == 3, 1'b1, tdo);
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    // DR scan through the one bit bypass register
    rnd = $random(seed);
    pattern = rnd[7:0];
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    for (int b = 0; b < 9; b++) begin
      tck_cycle(b == 8, (b < 8) ? pattern[b] : 1'b0, tdo);
      byp_read[b] = tdo;
    end
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    check_value("tdo bypass captured", 32'h0, 32'(byp_read[0]));
    check_value("tdo bypass", 32'(pattern), 32'(byp_read[8:1]));
    apply_reset(1'b0);
    run_random(50, 1'b0);
    end_test("bypass and return to functional");

    finish_run();
  end

endmodule : chip_io_tb

`default_nettype wire

// File: src/chip_io_top.sv
////////////////////
// Pad side top level, joins control, JTAG overlay, pad ring and TAP
// Pads and core connect through plain vector ports
////////////////////

`timescale 1ns/1ps
`default_nettype none

module chip_io_top import chip_io_pkg::*; #(
  parameter int          JtagEnIdx    = 7,
  parameter int          TrstIdx      = 6,
  parameter int          TckIdx       = 8,
  parameter int          TmsIdx       = 9,   // TMS idles high
  parameter int          TdiIdx       = 10,
  parameter int          TdoIdx       = 11,
  parameter io_vec_t     TieOffValues = io_vec_t'(1) << TmsIdx,
  parameter logic [31:0] IdCode       = 32'h1000_36CF
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Package pins
  input  io_vec_t   pad_in_i,
  output io_vec_t   pad_out_o,
  output io_vec_t   pad_oe_o,
  // Core side
  input  io_vec_t   core_out_i,
  input  io_vec_t   core_oe_i,
  output io_vec_t   core_in_o,
  // Attribute writes
  input  logic      cfg_we_i,
  input  pad_idx_t  cfg_idx_i,
  input  pad_attr_t cfg_attr_i,
  output logic      jtag_active_o
);

  pad_bus_if pad_bus ();
  jtag_if    jtag_bus ();

  logic                   jtag_mode;
  logic                   pads_en;
  pad_attr_t [NumIos-1:0] pad_attr;

  ////////////////////
  // Control
  ////////////////////

  io_ctrl #(
    .JtagEnIdx ( JtagEnIdx )
  ) io_ctrl_i (
    .clk_i       ( clk_i                     ),
    .arst_n_i    ( arst_n_i                  ),
    .strap_pad_i ( pad_bus.in[JtagEnIdx]     ),  // Before the overlay
    .cfg_we_i    ( cfg_we_i                  ),
    .cfg_idx_i   ( cfg_idx_i                 ),
    .cfg_attr_i  ( cfg_attr_i                ),
    .jtag_mode_o ( jtag_mode                 ),
    .pads_en_o   ( pads_en                   ),
    .attr_o      ( pad_attr                  )
  );

  assign jtag_active_o = jtag_mode;

  ////////////////////
  // Pad path
  ////////////////////

  jtag_overlay #(
    .JtagEnIdx    ( JtagEnIdx    ),
    .TrstIdx      ( TrstIdx      ),
    .TckIdx       ( TckIdx       ),
    .TmsIdx       ( TmsIdx       ),
    .TdiIdx       ( TdiIdx       ),
    .TdoIdx       ( TdoIdx       ),
    .TieOffValues ( TieOffValues )
  ) jtag_overlay_i (
    .jtag_mode_i ( jtag_mode       ),
    .pads_en_i   ( pads_en         ),
    .core_out_i  ( core_out_i      ),
    .core_oe_i   ( core_oe_i       ),
    .core_in_o   ( core_in_o       ),
    .bus         ( pad_bus.mux     ),
    .jtag        ( jtag_bus.host   )
  );

  pad_ring pad_ring_i (
    .bus       ( pad_bus.ring ),
    .attr_i    ( pad_attr     ),
    .pad_in_i  ( pad_in_i     ),
    .pad_out_o ( pad_out_o    ),
    .pad_oe_o  ( pad_oe_o     )
  );

  jtag_tap #(
    .IdCode ( IdCode )
  ) jtag_tap_i (
    .jtag ( jtag_bus.tap )
  );

endmodule : chip_io_top

`default_nettype wire

// File: src/jtag_tap.sv
////////////////////
// Minimal JTAG TAP with IDCODE and BYPASS
// Clocked by the pad TCK, TDO launched on the falling edge
////////////////////

`timescale 1ns/1ps
`default_nettype none

module jtag_tap import chip_io_pkg::*; #(
  parameter logic [31:0] IdCode = 32'h1000_36CF
) (
  jtag_if.tap jtag
);

  localparam ir_t IrIdcode = 4'b0001;
  localparam ir_t IrBypass = 4'b1111;

  typedef enum logic [3:0] {
    TestLogicReset, RunTestIdle,
    SelectDrScan, CaptureDr, ShiftDr, Exit1Dr, PauseDr, Exit2Dr, UpdateDr,
    SelectIrScan, CaptureIr, ShiftIr, Exit1Ir, PauseIr, Exit2Ir, UpdateIr
  } tap_state_e;

  tap_state_e  state_q;
  tap_state_e  state_d;
  ir_t         ir_q;
  ir_t         ir_sr;
  logic [31:0] idcode_sr;
  logic        bypass_q;
  logic        dr_bit;
  logic        tdo_d;
  logic        tdo_q;

  ////////////////////
  // TAP FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      TestLogicReset: state_d = jtag.tms ? TestLogicReset : RunTestIdle;
      RunTestIdle:    state_d = jtag.tms ? SelectDrScan : RunTestIdle;
      SelectDrScan:   state_d = jtag.tms ? SelectIrScan : CaptureDr;
      CaptureDr:      state_d = jtag.tms ? Exit1Dr : ShiftDr;
      ShiftDr:        state_d = jtag.tms ? Exit1Dr : ShiftDr;
      Exit1Dr:        state_d = jtag.tms ? UpdateDr : PauseDr;
      PauseDr:        state_d = jtag.tms ? Exit2Dr : PauseDr;
      Exit2Dr:        state_d = jtag.tms ? UpdateDr : ShiftDr;
      UpdateDr:       state_d = jtag.tms ? SelectDrScan : RunTestIdle;
      SelectIrScan:   state_d = jtag.tms ? TestLogicReset : CaptureIr;
      CaptureIr:      state_d = jtag.tms ? Exit1Ir : ShiftIr;
      ShiftIr:        state_d = jtag.tms ? Exit1Ir : ShiftIr;
      Exit1Ir:        state_d = jtag.tms ? UpdateIr : PauseIr;
      PauseIr:        state_d = jtag.tms ? Exit2Ir : PauseIr;
      Exit2Ir:        state_d = jtag.tms ? UpdateIr : ShiftIr;
      UpdateIr:       state_d = jtag.tms ? SelectDrScan : RunTestIdle;
      default:        state_d = TestLogicReset;
    endcase
  end

  always_ff @(posedge jtag.tck or negedge jtag.trst_n) begin
    if (!jtag.trst_n) begin
      state_q <= TestLogicReset;
      ir_q    <= IrIdcode;
    end else begin
      state_q <= state_d;
      if (state_q == TestLogicReset) begin
        ir_q <= IrIdcode;             // Five TMS highs land here too
      end else if (state_q == UpdateIr) begin
        ir_q <= ir_sr;
      end
    end
  end

  ////////////////////
  // Shift registers
  ////////////////////

  always_ff @(posedge jtag.tck) begin
    case (state_q)
      CaptureIr: ir_sr <= 4'b0101;    // Fixed 01 in the low bits
      ShiftIr:   ir_sr <= {jtag.tdi, ir_sr[3:1]};
      CaptureDr: begin
        idcode_sr <= IdCode;
        bypass_q  <= 1'b0;
      end
      ShiftDr: begin
        idcode_sr <= {jtag.tdi, idcode_sr[31:1]};  // LSB out first
        bypass_q  <= jtag.tdi;
      end
      default: ;
    endcase
  end

  // Unknown codes fall back to bypass
  always_comb begin
    case (ir_q)
      IrIdcode: dr_bit = idcode_sr[0];
      IrBypass: dr_bit = bypass_q;
      default:  dr_bit = bypass_q;
    endcase
  end

  assign tdo_d = (state_q == ShiftIr) ? ir_sr[0] :
                 (state_q == ShiftDr) ? dr_bit : 1'b0;

  always_ff @(negedge jtag.tck or negedge jtag.trst_n) begin
    if (!jtag.trst_n) begin
      tdo_q <= 1'b0;
    end else begin
      tdo_q <= tdo_d;
    end
  end

  assign jtag.tdo = tdo_q;

endmodule : jtag_tap

`default_nettype wire

// File: src/pad_ring.sv
////////////////////
// Pad ring model, applies invert, open drain and input disable per pad
// Pads are split into in, out and oe, no real bidirectional cells
////////////////////

`timescale 1ns/1ps
`default_nettype none

module pad_ring import chip_io_pkg::*; (
  pad_bus_if.ring                bus,
  input  pad_attr_t [NumIos-1:0] attr_i,
  input  io_vec_t                pad_in_i,
  output io_vec_t                pad_out_o,
  output io_vec_t                pad_oe_o
);

  io_vec_t out_inv;

  ////////////////////
  // Output path
  ////////////////////

  always_comb begin
    for (int i = 0; i < NumIos; i++) begin
      out_inv[i] = bus.out[i] ^ attr_i[i][AttrInvert];

      if (attr_i[i][AttrOpenDrain]) begin
        // Only ever pulls low, released for a logical one
        pad_out_o[i] = 1'b0;
        pad_oe_o[i]  = bus.oe[i] & ~out_inv[i] & bus.pads_en;
      end else begin
        pad_out_o[i] = out_inv[i];
        pad_oe_o[i]  = bus.oe[i] & bus.pads_en;
      end
    end
  end

  ////////////////////
  // Input path
  ////////////////////

  always_comb begin
    for (int i = 0; i < NumIos; i++) begin
      bus.in[i] = (pad_in_i[i] ^ attr_i[i][AttrInvert]) &
                  ~attr_i[i][AttrInDisable];  // Disabled input reads 0
    end
  end

endmodule : pad_ring

`default_nettype wire

// File: src/jtag_overlay.sv
////////////////////
// JTAG overlay mux that steals the fixed JTAG pads from the core in JTAG mode
// Sits between core signals and the pad bus and passes all pads through otherwise
////////////////////

`timescale 1ns/1ps
`default_nettype none

module jtag_overlay import chip_io_pkg::*; #(
  parameter int      JtagEnIdx    = 7,
  parameter int      TrstIdx      = 6,
  parameter int      TckIdx       = 8,
  parameter int      TmsIdx       = 9,
  parameter int      TdiIdx       = 10,
  parameter int      TdoIdx       = 11,
  parameter io_vec_t TieOffValues = io_vec_t'(1) << TmsIdx
) (
  input  logic       jtag_mode_i,
  input  logic       pads_en_i,
  input  io_vec_t    core_out_i,
  input  io_vec_t    core_oe_i,
  output io_vec_t    core_in_o,
  pad_bus_if.mux     bus,
  jtag_if.host       jtag
);

  // Pads owned by the TAP in JTAG mode
  localparam io_vec_t JtagInMask = (io_vec_t'(1) << TckIdx) | (io_vec_t'(1) << TmsIdx) |
                                   (io_vec_t'(1) << TdiIdx) | (io_vec_t'(1) << TrstIdx);
  localparam io_vec_t JtagMask   = JtagInMask | (io_vec_t'(1) << TdoIdx);

  assign bus.pads_en = pads_en_i;

  always_comb begin
    // Functional defaults with the TAP parked in reset
    bus.out     = core_out_i;
    bus.oe      = core_oe_i;
    core_in_o   = bus.in;
    jtag.tck    = 1'b0;
    jtag.tms    = 1'b1;
    jtag.trst_n = 1'b0;
    jtag.tdi    = 1'b0;

    if (jtag_mode_i) begin
      jtag.tck    = bus.in[TckIdx];
      jtag.tms    = bus.in[TmsIdx];
      jtag.trst_n = bus.in[TrstIdx];
      jtag.tdi    = bus.in[TdiIdx];

      bus.oe         = core_oe_i & ~JtagMask;  // JTAG inputs never driven
      bus.out[TdoIdx] = jtag.tdo;
      bus.oe[TdoIdx]  = 1'b1;

      // Core sees fixed idle levels on the stolen pads
      core_in_o = (bus.in & ~JtagMask) | (TieOffValues & JtagMask);
    end
  end

  // Strap pad must not be one of the stolen pads
  initial begin
    assert (!JtagMask[JtagEnIdx])
      else $error("strap pad %0d overlaps a JTAG pad", JtagEnIdx);
  end

  // TAP only owns the TDO pad once the pads are open
  always_comb begin
    assert (!jtag_mode_i || pads_en_i)
      else $error("JTAG mode while pad outputs are disabled");
  end

endmodule : jtag_overlay

`default_nettype wire

// File: src/io_ctrl.sv
////////////////////
// Strap sampling after reset, pad output gating and per-pad attribute registers
// Strap bit comes straight from the pad ring, attributes go back to it
////////////////////

`timescale 1ns/1ps
`default_nettype none

module io_ctrl import chip_io_pkg::*; #(
  parameter int JtagEnIdx = 7
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   strap_pad_i,
  input  logic                   cfg_we_i,
  input  pad_idx_t               cfg_idx_i,
  input  pad_attr_t              cfg_attr_i,
  output logic                   jtag_mode_o,
  output logic                   pads_en_o,
  output pad_attr_t [NumIos-1:0] attr_o
);

  logic [1:0]              strap_sync_q;
  ctrl_state_e             state_q;
  ctrl_state_e             state_d;
  logic                    mode_decided;
  logic                    attr_wr_ok;
  pad_attr_t [NumIos-1:0]  attr_q;

  ////////////////////
  // Strap FSM
  ////////////////////

  // Two flop synchroniser on the raw strap pad
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      strap_sync_q <= 2'b00;
    end else begin
      strap_sync_q <= {strap_sync_q[0], strap_pad_i};
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      CtrlReset:  state_d = CtrlSync;
      CtrlSync:   state_d = CtrlSample;
      CtrlSample: state_d = strap_sync_q[1] ? CtrlJtag : CtrlFunc;
      default:    state_d = state_q;  // Mode held until next reset
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CtrlReset;
    end else begin
      state_q <= state_d;
    end
  end

  assign mode_decided = (state_q == CtrlFunc) || (state_q == CtrlJtag);
  assign jtag_mode_o  = (state_q == CtrlJtag);
  assign pads_en_o    = mode_decided;   // No pad drives until the mode is known

  ////////////////////
  // Attributes
  ////////////////////

  // Strap pad attributes stay clear while the strap is still being sampled
  assign attr_wr_ok = cfg_we_i && (cfg_idx_i < pad_idx_t'(NumIos)) &&
                      (mode_decided || (cfg_idx_i != pad_idx_t'(JtagEnIdx)));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      attr_q <= '0;
    end else if (attr_wr_ok) begin
      attr_q[cfg_idx_i] <= cfg_attr_i;
    end
  end

  assign attr_o = attr_q;

  // Config writes only address existing pads
  a_cfg_idx_range : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cfg_we_i |-> (cfg_idx_i < pad_idx_t'(NumIos))
  ) else $error("attribute write to pad index %0d", cfg_idx_i);

  // Once decided the mode is locked until reset
  a_mode_locked : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    mode_decided |=> (mode_decided && $stable(jtag_mode_o))
  ) else $error("mode changed after strap sampling");

endmodule : io_ctrl

`default_nettype wire

// File: src/chip_io_if.sv
////////////////////
// Pad bus between overlay mux and pad ring, and the JTAG wires to the TAP
// Instantiated once each in the top level
////////////////////

`timescale 1ns/1ps
`default_nettype none

// Core-facing side of the pad ring
interface pad_bus_if import chip_io_pkg::*; ();

  io_vec_t out;      // Pad output value before attributes
  io_vec_t oe;       // Pad output enable before gating
  io_vec_t in;       // Pad input after attributes
  logic    pads_en;  // Global output enable gate

  modport mux (
    output out,
    output oe,
    output pads_en,
    input  in
  );

  modport ring (
    input  out,
    input  oe,
    input  pads_en,
    output in
  );

endinterface : pad_bus_if

// JTAG wires from the overlay mux to the TAP
interface jtag_if ();

  logic tck;
  logic tms;
  logic trst_n;
  logic tdi;
  logic tdo;

  modport host (
    output tck,
    output tms,
    output trst_n,
    output tdi,
    input  tdo
  );

  modport tap (
    input  tck,
    input  tms,
    input  trst_n,
    input  tdi,
    output tdo
  );

endinterface : jtag_if

`default_nettype wire

// File: src/chip_io_pkg.sv
////////////////////
// Pad counts, widths and the control FSM states shared by the pad-side blocks
// Pulled in by wildcard import in each module header
////////////////////

`default_nettype none

package chip_io_pkg;

  // Pad counts, DIOs sit above the MIOs in every vector
  localparam int NumMio = 8;
  localparam int NumDio = 4;
  localparam int NumIos = NumMio + NumDio;

  // Bit positions inside one pad attribute
  localparam int AttrInvert    = 0;
  localparam int AttrOpenDrain = 1;
  localparam int AttrInDisable = 2;

  typedef logic [NumIos-1:0] io_vec_t;    // One bit per pad
  typedef logic [2:0]        pad_attr_t;  // {in disable, open drain, invert}
  typedef logic [3:0]        pad_idx_t;
  typedef logic [3:0]        ir_t;        // TAP instruction

  // Strap sampling sequence after reset
  typedef enum logic [2:0] {
    CtrlReset,
    CtrlSync,
    CtrlSample,
    CtrlFunc,
    CtrlJtag
  } ctrl_state_e;

endpackage : chip_io_pkg

`default_nettype wire
